//--- rover_cmd_pkg.sv
`default_nettype none

package rover_cmd_pkg;

    // ~ remote keys ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // decoded byte from the ir remote.
    typedef logic [7:0] key_code_t;

    // mode selection keys.
    localparam key_code_t KEY_CAM    = 8'h0f;
    localparam key_code_t KEY_REMOTE = 8'h13;
    localparam key_code_t KEY_IDLE   = 8'h10;

    // manual drive keys, used in remote mode only.
    localparam key_code_t KEY_FWD    = 8'h18;
    localparam key_code_t KEY_LEFT   = 8'h08;
    localparam key_code_t KEY_RIGHT  = 8'h5a;
    localparam key_code_t KEY_STOP   = 8'h1c;

    // ~ camera inputs ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // target direction, anything else is unknown.
    typedef logic [2:0] cam_dir_t;
    localparam cam_dir_t DIR_LEFT   = 3'b001;
    localparam cam_dir_t DIR_RIGHT  = 3'b010;
    localparam cam_dir_t DIR_CENTER = 3'b011;

    // speed class, 3 is invalid.
    typedef logic [1:0] speed_class_t;
    localparam speed_class_t SPEED_SLOW   = 2'd0;
    localparam speed_class_t SPEED_MEDIUM = 2'd1;
    localparam speed_class_t SPEED_FAST   = 2'd2;

    // ~ state encodings ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        MODE_IDLE   = 2'b00,
        MODE_CAM    = 2'b01,
        MODE_REMOTE = 2'b10
    } rover_mode_e;

    // pause is held whenever camera mode is not active.
    typedef enum logic [1:0] {
        CAM_SEARCH = 2'b00,
        CAM_FOLLOW = 2'b01,
        CAM_PAUSE  = 2'b11
    } cam_state_e;

    typedef enum logic [2:0] {
        DRV_STOP   = 3'b000,
        DRV_LEFT   = 3'b001,
        DRV_RIGHT  = 3'b010,
        DRV_SLOW   = 3'b011,
        DRV_MEDIUM = 3'b100,
        DRV_FAST   = 3'b101
    } drive_cmd_e;

endpackage

`default_nettype wire

//--- rover_motor_pkg.sv
`default_nettype none

package rover_motor_pkg;

    // ~ wheels and pwm ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // left wheel first, then right.
    localparam int NUM_WHEELS  = 2;
    localparam int WHEEL_LEFT  = 0;
    localparam int WHEEL_RIGHT = 1;

    // clock cycles per pwm period.
    localparam int PWM_PERIOD = 100;

    // high cycles per period, also wide enough for the period counter.
    typedef logic [6:0] duty_t;

    // ~ duty levels ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam duty_t DUTY_TURN   = 7'd40;
    localparam duty_t DUTY_SLOW   = 7'd30;
    localparam duty_t DUTY_MEDIUM = 7'd60;
    localparam duty_t DUTY_FAST   = 7'd90;

    // command for one wheel channel.
    typedef struct packed {
        duty_t duty;
        logic  reverse;
    } wheel_cmd_t;

endpackage

`default_nettype wire

//--- drive_mode_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module drive_mode_fsm (
    input  wire                                clk_50,
    input  wire                                rst_n,
    input  wire rover_cmd_pkg::key_code_t      key_code,
    input  wire                                key_valid,
    input  wire                                target_seen,
    input  wire rover_cmd_pkg::cam_dir_t       target_dir,
    input  wire rover_cmd_pkg::speed_class_t   speed_class,
    output rover_cmd_pkg::rover_mode_e         mode,
    output rover_cmd_pkg::cam_state_e          cam_state,
    output rover_cmd_pkg::drive_cmd_e          drive_cmd,
    output logic                               mode_change
);

    rover_cmd_pkg::rover_mode_e mode_next;
    rover_cmd_pkg::cam_state_e  cam_next;
    rover_cmd_pkg::drive_cmd_e  drive_next;
    rover_cmd_pkg::drive_cmd_e  follow_cmd;
    rover_cmd_pkg::drive_cmd_e  remote_cmd;

    // ~ mode ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // keys only count with their strobe.
    always_comb begin
        mode_next = mode;
        if (key_valid) begin
            case (mode)
                rover_cmd_pkg::MODE_IDLE: begin
                    if (key_code == rover_cmd_pkg::KEY_CAM)
                        mode_next = rover_cmd_pkg::MODE_CAM;
                    else if (key_code == rover_cmd_pkg::KEY_REMOTE)
                        mode_next = rover_cmd_pkg::MODE_REMOTE;
                end
                rover_cmd_pkg::MODE_CAM: begin
                    if (key_code == rover_cmd_pkg::KEY_REMOTE)
                        mode_next = rover_cmd_pkg::MODE_REMOTE;
                    else if (key_code == rover_cmd_pkg::KEY_IDLE)
                        mode_next = rover_cmd_pkg::MODE_IDLE;
                end
                rover_cmd_pkg::MODE_REMOTE: begin
                    if (key_code == rover_cmd_pkg::KEY_CAM)
                        mode_next = rover_cmd_pkg::MODE_CAM;
                    else if (key_code == rover_cmd_pkg::KEY_IDLE)
                        mode_next = rover_cmd_pkg::MODE_IDLE;
                end
                default: mode_next = rover_cmd_pkg::MODE_IDLE;
            endcase
        end
    end

    // ~ camera tracking ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // decided on the next mode, so leaving camera mode pauses at once.
    always_comb begin
        cam_next = cam_state;
        if (mode_next != rover_cmd_pkg::MODE_CAM) begin
            cam_next = rover_cmd_pkg::CAM_PAUSE;
        end else begin
            case (cam_state)
                rover_cmd_pkg::CAM_PAUSE:  cam_next = rover_cmd_pkg::CAM_SEARCH;
                rover_cmd_pkg::CAM_SEARCH: begin
                    if (target_seen)
                        cam_next = rover_cmd_pkg::CAM_FOLLOW;
                end
                rover_cmd_pkg::CAM_FOLLOW: begin
                    if (!target_seen)
                        cam_next = rover_cmd_pkg::CAM_SEARCH;
                end
                default: cam_next = rover_cmd_pkg::CAM_PAUSE;
            endcase
        end
    end

    // ~ drive command ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // steering while following; unknown direction or bad speed stops.
    always_comb begin
        follow_cmd = rover_cmd_pkg::DRV_STOP;
        case (target_dir)
            rover_cmd_pkg::DIR_LEFT:  follow_cmd = rover_cmd_pkg::DRV_LEFT;
            rover_cmd_pkg::DIR_RIGHT: follow_cmd = rover_cmd_pkg::DRV_RIGHT;
            rover_cmd_pkg::DIR_CENTER: begin
                case (speed_class)
                    rover_cmd_pkg::SPEED_SLOW:   follow_cmd = rover_cmd_pkg::DRV_SLOW;
                    rover_cmd_pkg::SPEED_MEDIUM: follow_cmd = rover_cmd_pkg::DRV_MEDIUM;
                    rover_cmd_pkg::SPEED_FAST:   follow_cmd = rover_cmd_pkg::DRV_FAST;
                    default:                     follow_cmd = rover_cmd_pkg::DRV_STOP;
                endcase
            end
            default: follow_cmd = rover_cmd_pkg::DRV_STOP;
        endcase
    end

    // remote mode holds the last command until a drive key arrives.
    always_comb begin
        remote_cmd = drive_cmd;
        if (mode != rover_cmd_pkg::MODE_REMOTE) begin
            remote_cmd = rover_cmd_pkg::DRV_STOP;
        end else if (key_valid) begin
            case (key_code)
                rover_cmd_pkg::KEY_FWD:   remote_cmd = rover_cmd_pkg::DRV_MEDIUM;
                rover_cmd_pkg::KEY_LEFT:  remote_cmd = rover_cmd_pkg::DRV_LEFT;
                rover_cmd_pkg::KEY_RIGHT: remote_cmd = rover_cmd_pkg::DRV_RIGHT;
                rover_cmd_pkg::KEY_STOP:  remote_cmd = rover_cmd_pkg::DRV_STOP;
                default:                  remote_cmd = drive_cmd;
            endcase
        end
    end

    always_comb begin
        case (mode_next)
            rover_cmd_pkg::MODE_CAM: begin
                if (cam_next == rover_cmd_pkg::CAM_FOLLOW)
                    drive_next = follow_cmd;
                else
                    drive_next = rover_cmd_pkg::DRV_RIGHT;
            end
            rover_cmd_pkg::MODE_REMOTE: drive_next = remote_cmd;
            default:                    drive_next = rover_cmd_pkg::DRV_STOP;
        endcase
    end

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            mode        <= rover_cmd_pkg::MODE_IDLE;
            cam_state   <= rover_cmd_pkg::CAM_PAUSE;
            drive_cmd   <= rover_cmd_pkg::DRV_STOP;
            mode_change <= 1'b0;
        end else begin
            mode        <= mode_next;
            cam_state   <= cam_next;
            drive_cmd   <= drive_next;
            mode_change <= (mode_next != mode) || (cam_next != cam_state);
        end
    end

endmodule

`default_nettype wire

//--- wheel_mixer.sv
`timescale 1ns/10ps
`default_nettype none

module wheel_mixer (
    input  wire                                          clk_50,
    input  wire                                          rst_n,
    input  wire rover_cmd_pkg::drive_cmd_e               drive_cmd,
    output rover_motor_pkg::wheel_cmd_t [rover_motor_pkg::NUM_WHEELS-1:0] wheel_cmd
);

    rover_motor_pkg::wheel_cmd_t [rover_motor_pkg::NUM_WHEELS-1:0] mix;

    // ~ differential mix ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // turns spin the wheels against each other at turn duty.
    always_comb begin
        mix = '0;
        case (drive_cmd)
            rover_cmd_pkg::DRV_LEFT: begin
                mix[rover_motor_pkg::WHEEL_LEFT] =
                    '{duty: rover_motor_pkg::DUTY_TURN, reverse: 1'b1};
                mix[rover_motor_pkg::WHEEL_RIGHT] =
                    '{duty: rover_motor_pkg::DUTY_TURN, reverse: 1'b0};
            end
            rover_cmd_pkg::DRV_RIGHT: begin
                mix[rover_motor_pkg::WHEEL_LEFT] =
                    '{duty: rover_motor_pkg::DUTY_TURN, reverse: 1'b0};
                mix[rover_motor_pkg::WHEEL_RIGHT] =
                    '{duty: rover_motor_pkg::DUTY_TURN, reverse: 1'b1};
            end
            rover_cmd_pkg::DRV_SLOW: begin
                mix[rover_motor_pkg::WHEEL_LEFT] =
                    '{duty: rover_motor_pkg::DUTY_SLOW, reverse: 1'b0};
                mix[rover_motor_pkg::WHEEL_RIGHT] =
                    '{duty: rover_motor_pkg::DUTY_SLOW, reverse: 1'b0};
            end
            rover_cmd_pkg::DRV_MEDIUM: begin
                mix[rover_motor_pkg::WHEEL_LEFT] =
                    '{duty: rover_motor_pkg::DUTY_MEDIUM, reverse: 1'b0};
                mix[rover_motor_pkg::WHEEL_RIGHT] =
                    '{duty: rover_motor_pkg::DUTY_MEDIUM, reverse: 1'b0};
            end
            rover_cmd_pkg::DRV_FAST: begin
                mix[rover_motor_pkg::WHEEL_LEFT] =
                    '{duty: rover_motor_pkg::DUTY_FAST, reverse: 1'b0};
                mix[rover_motor_pkg::WHEEL_RIGHT] =
                    '{duty: rover_motor_pkg::DUTY_FAST, reverse: 1'b0};
            end
            // stop and unused codes leave both wheels idle.
            default: mix = '0;
        endcase
    end

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            wheel_cmd <= '0;
        end else begin
            wheel_cmd <= mix;
        end
    end

endmodule

`default_nettype wire

//--- wheel_pwm.sv
`timescale 1ns/10ps
`default_nettype none

module wheel_pwm (
    input  wire                          clk_50,
    input  wire                          rst_n,
    input  wire rover_motor_pkg::wheel_cmd_t cmd,
    output logic                         pwm,
    output logic                         reverse
);

    localparam rover_motor_pkg::duty_t CNT_LAST =
        rover_motor_pkg::duty_t'(rover_motor_pkg::PWM_PERIOD - 1);

    rover_motor_pkg::duty_t cnt;
    rover_motor_pkg::duty_t duty_q;
    rover_motor_pkg::duty_t duty_now;

    // ~ period counter ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt == CNT_LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // at count 0 the incoming duty is used directly, so the whole
    // period runs on the new command.
    assign duty_now = (cnt == '0) ? cmd.duty : duty_q;

    // ~ latch and output ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // pwm and reverse are registered, one cycle behind the count.
    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            duty_q  <= '0;
            reverse <= 1'b0;
            pwm     <= 1'b0;
        end else begin
            if (cnt == '0) begin
                duty_q  <= cmd.duty;
                reverse <= cmd.reverse;
            end
            pwm <= (cnt < duty_now);
        end
    end

endmodule

`default_nettype wire

//--- rover_top.sv
`timescale 1ns/10ps
`default_nettype none

module rover_top (
    input  wire                                clk_50,
    input  wire                                rst_n,
    input  wire rover_cmd_pkg::key_code_t      key_code,
    input  wire                                key_valid,
    input  wire                                target_seen,
    input  wire rover_cmd_pkg::cam_dir_t       target_dir,
    input  wire rover_cmd_pkg::speed_class_t   speed_class,
    output rover_cmd_pkg::rover_mode_e         mode,
    output rover_cmd_pkg::cam_state_e          cam_state,
    output rover_cmd_pkg::drive_cmd_e          drive_cmd,
    output logic                               mode_change,
    output logic [rover_motor_pkg::NUM_WHEELS-1:0] pwm,
    output logic [rover_motor_pkg::NUM_WHEELS-1:0] reverse
);

    rover_motor_pkg::wheel_cmd_t [rover_motor_pkg::NUM_WHEELS-1:0] wheel_cmd;

    drive_mode_fsm i_drive_mode_fsm (
        .clk_50      (clk_50),
        .rst_n       (rst_n),
        .key_code    (key_code),
        .key_valid   (key_valid),
        .target_seen (target_seen),
        .target_dir  (target_dir),
        .speed_class (speed_class),
        .mode        (mode),
        .cam_state   (cam_state),
        .drive_cmd   (drive_cmd),
        .mode_change (mode_change)
    );

    wheel_mixer i_wheel_mixer (
        .clk_50    (clk_50),
        .rst_n     (rst_n),
        .drive_cmd (drive_cmd),
        .wheel_cmd (wheel_cmd)
    );

    // ~ wheel channels ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one pwm channel per wheel, index 0 is the left wheel.
    for (genvar w = 0; w < rover_motor_pkg::NUM_WHEELS; w++) begin : g_wheel
        wheel_pwm i_wheel_pwm (
            .clk_50  (clk_50),
            .rst_n   (rst_n),
            .cmd     (wheel_cmd[w]),
            .pwm     (pwm[w]),
            .reverse (reverse[w])
        );
    end

endmodule

`default_nettype wire

//--- rover_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rover_tb;

    // one line of the vector file.
    typedef struct packed {
        rover_cmd_pkg::key_code_t    key;
        logic                        kv;
        logic                        seen;
        rover_cmd_pkg::cam_dir_t     dir;
        rover_cmd_pkg::speed_class_t spd;
        logic [1:0]                  mode;
        logic [1:0]                  cam;
        logic [2:0]                  drv;
        logic                        mc;
        rover_motor_pkg::duty_t      l_duty;
        logic                        l_rev;
        rover_motor_pkg::duty_t      r_duty;
        logic                        r_rev;
        logic                        meas;
    } vector_t;

    logic                                   clk_50;
    logic                                   rst_n;
    rover_cmd_pkg::key_code_t               key_code;
    logic                                   key_valid;
    logic                                   target_seen;
    rover_cmd_pkg::cam_dir_t                target_dir;
    rover_cmd_pkg::speed_class_t            speed_class;
    rover_cmd_pkg::rover_mode_e             mode;
    rover_cmd_pkg::cam_state_e              cam_state;
    rover_cmd_pkg::drive_cmd_e              drive_cmd;
    logic                                   mode_change;
    logic [rover_motor_pkg::NUM_WHEELS-1:0] pwm;
    logic [rover_motor_pkg::NUM_WHEELS-1:0] reverse;

    vector_t vecs[$];
    logic    loaded;

    rover_top i_rover_top (
        .clk_50      (clk_50),
        .rst_n       (rst_n),
        .key_code    (key_code),
        .key_valid   (key_valid),
        .target_seen (target_seen),
        .target_dir  (target_dir),
        .speed_class (speed_class),
        .mode        (mode),
        .cam_state   (cam_state),
        .drive_cmd   (drive_cmd),
        .mode_change (mode_change),
        .pwm         (pwm),
        .reverse     (reverse)
    );

    initial begin
        clk_50 = 1'b0;
        forever #2 clk_50 = ~clk_50;
    end

    // ~ reporting ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("Fail at %0d ns: %s got %0d expected %0d", $time, name, got, expected);
            abort_run("value mismatch");
        end
    endtask

    // ~ vector file ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic load_vectors();
        int      fd;
        int      n;
        int      fld [14];
        string   line;
        byte     first;
        vector_t v;
        fd = $fopen("rover_vectors.txt", "r");
        if (fd == 0)
            abort_run("could not open rover_vectors.txt");
        while ($fgets(line, fd) > 0) begin
            first = line.getc(0);
            // skip comment and empty lines.
            if (line.len() > 1 && first != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %d %h %d %h %h",
                            fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                            fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13]);
                if (n != 14)
                    abort_run("a line of rover_vectors.txt has the wrong number of fields");
                v.key    = rover_cmd_pkg::key_code_t'(fld[0]);
                v.kv     = 1'(fld[1]);
                v.seen   = 1'(fld[2]);
                v.dir    = rover_cmd_pkg::cam_dir_t'(fld[3]);
                v.spd    = rover_cmd_pkg::speed_class_t'(fld[4]);
                v.mode   = 2'(fld[5]);
                v.cam    = 2'(fld[6]);
                v.drv    = 3'(fld[7]);
                v.mc     = 1'(fld[8]);
                v.l_duty = rover_motor_pkg::duty_t'(fld[9]);
                v.l_rev  = 1'(fld[10]);
                v.r_duty = rover_motor_pkg::duty_t'(fld[11]);
                v.r_rev  = 1'(fld[12]);
                v.meas   = 1'(fld[13]);
                vecs.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    // ~ stimulus and checks ~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // counts high cycles over one full period once the command has settled.
    task automatic measure_wheels(input int idx, input vector_t v);
        int hi_l;
        int hi_r;
        hi_l = 0;
        hi_r = 0;
        repeat (2 * rover_motor_pkg::PWM_PERIOD) @(negedge clk_50);
        check_value($sformatf("step %0d reverse[0]", idx),
                    int'(reverse[rover_motor_pkg::WHEEL_LEFT]), int'(v.l_rev));
        check_value($sformatf("step %0d reverse[1]", idx),
                    int'(reverse[rover_motor_pkg::WHEEL_RIGHT]), int'(v.r_rev));
        repeat (rover_motor_pkg::PWM_PERIOD) begin
            @(negedge clk_50);
            if (pwm[rover_motor_pkg::WHEEL_LEFT])
                hi_l++;
            if (pwm[rover_motor_pkg::WHEEL_RIGHT])
                hi_r++;
        end
        check_value($sformatf("step %0d pwm[0] duty", idx), hi_l, int'(v.l_duty));
        check_value($sformatf("step %0d pwm[1] duty", idx), hi_r, int'(v.r_duty));
    endtask

    // key_valid is a one-cycle strobe while the camera levels stay held.
    task automatic apply_step(input int idx, input vector_t v);
        @(posedge clk_50);
        key_code    <= v.key;
        key_valid   <= v.kv;
        target_seen <= v.seen;
        target_dir  <= v.dir;
        speed_class <= v.spd;
        @(posedge clk_50);
        key_valid <= 1'b0;
        @(negedge clk_50);
        check_value($sformatf("step %0d mode", idx), int'(mode), int'(v.mode));
        check_value($sformatf("step %0d cam_state", idx), int'(cam_state), int'(v.cam));
        check_value($sformatf("step %0d drive_cmd", idx), int'(drive_cmd), int'(v.drv));
        check_value($sformatf("step %0d mode_change", idx), int'(mode_change), int'(v.mc));
        if (v.meas)
            measure_wheels(idx, v);
    endtask

    // ~ main sequence and watchdog ~~~~~~~~~~~~~~~~~~~~

    initial begin
        int limit;
        wait (loaded);
        limit = vecs.size() * (3 * rover_motor_pkg::PWM_PERIOD + 10) + 20;
        repeat (limit) @(posedge clk_50);
        abort_run("the run timed out before all vectors were applied");
    end

    initial begin
        rst_n       = 1'b0;
        key_code    = '0;
        key_valid   = 1'b0;
        target_seen = 1'b0;
        target_dir  = '0;
        speed_class = '0;
        loaded      = 1'b0;
        load_vectors();
        loaded = 1'b1;
        repeat (8) @(posedge clk_50);
        rst_n <= 1'b1;
        for (int i = 0; i < vecs.size(); i++)
            apply_step(i + 1, vecs[i]);
        if (vecs.size() == 0) begin
            abort_run("no test vectors were read");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- rover_vectors.txt
# key key_valid target_seen target_dir speed_class mode cam_state drive_cmd mode_change (hex)
# left_duty(dec) left_rev right_duty(dec) right_rev measure
00 0 0 0 0 0 3 0 0 0 0 0 0 1
10 1 0 0 0 0 3 0 0 0 0 0 0 0
0f 0 0 0 0 0 3 0 0 0 0 0 0 0
13 1 0 0 0 2 3 0 1 0 0 0 0 0
10 1 0 0 0 0 3 0 1 0 0 0 0 0
0f 1 0 0 0 1 0 2 1 40 0 40 1 1
0f 1 0 0 0 1 0 2 0 40 0 40 1 0
00 0 1 1 0 1 1 1 1 40 1 40 0 1
00 0 1 2 0 1 1 2 0 40 0 40 1 0
00 0 1 3 0 1 1 3 0 30 0 30 0 1
00 0 1 3 1 1 1 4 0 60 0 60 0 1
00 0 1 3 2 1 1 5 0 90 0 90 0 1
00 0 1 3 3 1 1 0 0 0 0 0 0 1
00 0 1 4 0 1 1 0 0 0 0 0 0 0
00 0 0 4 0 1 0 2 1 40 0 40 1 0
13 1 0 0 0 2 3 0 1 0 0 0 0 0
18 1 0 0 0 2 3 4 0 60 0 60 0 1
08 1 0 0 0 2 3 1 0 40 1 40 0 1
5a 1 0 0 0 2 3 2 0 40 0 40 1 1
1c 1 0 0 0 2 3 0 0 0 0 0 0 1
0f 1 0 0 0 1 0 2 1 40 0 40 1 0
10 1 0 0 0 0 3 0 1 0 0 0 0 0

//--- all.f
rover_cmd_pkg.sv
rover_motor_pkg.sv
drive_mode_fsm.sv
wheel_mixer.sv
wheel_pwm.sv
rover_top.sv
rover_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the rover testbench, pass is decided from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary -f all.f --top-module rover_tb -o rover_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rover_sim > sim.log 2>&1
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
    || { cat sim.log; echo "simulation failed"; exit 1; }
